// ==== sim.f ====
verilog/htif_pkg.sv
verilog/htif_steer.sv
verilog/htif_regs.sv
verilog/uart_lite_seq.sv
verilog/htif_bridge.sv
verification/bus_responder.sv
verification/htif_bridge_asserts.sv
verification/tb_htif_bridge.sv

// ==== verification/tb_htif_bridge.sv ====
// testbench for the HTIF console bridge
// random pass-through traffic, tohost/fromhost accesses and console
// sequences checked against a local model
`timescale 1ns/1ns

module tb_htif_bridge import htif_pkg::*;;
    localparam logic [63:0] TOHOST   = 64'h8000_1000;
    localparam logic [63:0] FROMHOST = 64'h8000_1040;
    localparam logic [63:0] UART     = 64'h1000_0000;
    localparam int SEED  = 53;
    localparam int NTXN  = 300;
    localparam int LIMIT = 200 * (NTXN + 16);

    logic clk = 1'b0;
    logic rst;
    addr_req_t core_aw, core_ar, mem_aw, mem_ar;
    wdata_t    core_w, mem_w;
    rdata_t    core_r, mem_r;
    logic core_awvalid, core_awready, core_wvalid, core_wready, core_bvalid, core_bready;
    logic core_arvalid, core_arready, core_rvalid, core_rready;
    logic mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
    logic mem_arvalid, mem_arready, mem_rvalid, mem_rready;

    integer      seed;
    int          errors = 0;
    int          cycles = 0;
    int          kind, n_log, n_acc;
    logic [63:0] model [logic [63:0]];
    logic [63:0] addr, data, got;
    logic [7:0]  ch;

    htif_bridge #(.TOHOST_ADDR(TOHOST), .FROMHOST_ADDR(FROMHOST), .UART_BASE(UART)) u_dut (.*);
    bus_responder #(.UART_BASE(UART), .SEED(SEED)) u_resp (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] g, input logic [63:0] e);
        if (g !== e) begin
            $display("FAIL %s got %h expected %h", name, g, e);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [63:0] a, input logic [63:0] d);
        bit aw_done, w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        core_aw = '{addr: a, len: '0};
        core_w  = '{data: d, strb: 8'hff, last: 1'b1};
        core_awvalid = 1'b1;
        core_wvalid  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            if (core_awvalid && core_awready) aw_done = 1'b1;
            if (core_wvalid && core_wready) w_done = 1'b1;
            @(posedge clk);
            #1;
            if (aw_done) core_awvalid = 1'b0;
            if (w_done) core_wvalid = 1'b0;
        end
        core_bready = 1'b1;
        do @(negedge clk); while (!core_bvalid);
        @(posedge clk);
        #1;
        core_bready = 1'b0;
    endtask

    task automatic bus_read(input logic [63:0] a, output logic [63:0] d);
        core_ar = '{addr: a, len: '0};
        core_arvalid = 1'b1;
        do @(negedge clk); while (!core_arready);
        @(posedge clk);
        #1;
        core_arvalid = 1'b0;
        core_rready  = 1'b1;
        do @(negedge clk); while (!core_rvalid);
        d = core_r.data;
        check_value("core_r.last", core_r.last, 64'h1);  // single beat
        @(posedge clk);
        #1;
        core_rready = 1'b0;
    endtask

    function automatic logic [63:0] pool_addr(input int i);
        return 64'h8000_0000 + 64'(i) * 8;
    endfunction

    initial begin
        seed = SEED;
        rst = 1'b1;
        core_aw = '0;
        core_w = '0;
        core_ar = '0;
        core_awvalid = 1'b0;
        core_wvalid  = 1'b0;
        core_bready  = 1'b0;
        core_arvalid = 1'b0;
        core_rready  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 16; i++) begin
            data = {$random(seed), $random(seed)};
            bus_write(pool_addr(i), data);
            model[pool_addr(i)] = data;
        end

        for (int t = 0; t < NTXN; t++) begin
            kind = $unsigned($random(seed)) % 10;
            n_log = u_resp.tx_log_data.size();
            n_acc = u_resp.uart_access_cnt;
            if (kind < 4) begin
                addr = pool_addr($unsigned($random(seed)) % 16);
                data = {$random(seed), $random(seed)};
                bus_write(addr, data);
                model[addr] = data;
            end else if (kind < 6) begin
                addr = pool_addr($unsigned($random(seed)) % 16);
                bus_read(addr, got);
                check_value("core_r.data", got, model[addr]);
            end else if (kind == 6) begin
                data = {$random(seed), $random(seed)} | 64'h1;
                bus_write(FROMHOST, data);
                bus_read(FROMHOST, got);
                check_value("fromhost", got, data);
                if (u_resp.uart_access_cnt != n_acc) begin
                    $display("fromhost access reached the UART");
                    errors++;
                end
            end else if (kind == 7) begin
                ch = $random(seed);
                u_resp.tx_full_cnt = $unsigned($random(seed)) % 4;
                bus_write(TOHOST, {8'h01, 8'h01, 40'd0, ch});
                bus_read(TOHOST, got);  // waits out the transmit sequence
                check_value("tohost", got, 64'h0);
                if (u_resp.tx_log_data.size() != n_log + 1) begin
                    $display("console write did not produce exactly one UART write");
                    errors++;
                end else begin
                    check_value("uart_wdata", u_resp.tx_log_data[n_log], 64'(ch) << 32);
                    check_value("uart_wstrb", u_resp.tx_log_strb[n_log], 64'h10);
                end
                check_value("tx_full_polls_left", u_resp.tx_full_cnt, 64'h0);
            end else if (kind == 8) begin
                data = {8'h02, 8'($random(seed)), 16'($random(seed)), 32'($random(seed))};
                bus_write(TOHOST, data);
                bus_read(TOHOST, got);
                check_value("tohost", got, 64'h0);
                if (u_resp.tx_log_data.size() != n_log) begin
                    $display("non-console tohost write reached the UART transmit FIFO");
                    errors++;
                end
            end else begin
                bus_write(FROMHOST, 64'h0);
                ch = $random(seed);
                if ($random(seed) & 1) u_resp.rx_q.push_back(ch);
                data = (u_resp.rx_q.size() > 0) ? {8'h01, 8'h00, 48'(u_resp.rx_q[0])} : 64'h0;
                bus_read(FROMHOST, got);
                check_value("fromhost", got, 64'h0);
                bus_read(FROMHOST, got);
                check_value("fromhost", got, data);
            end
        end

        $display("errors: %0d checks, %0d assertions after %0d transactions",
                 errors, u_dut.u_asserts.fail_cnt, NTXN);
        if (errors == 0 && u_dut.u_asserts.fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verification/htif_bridge_asserts.sv ====
// handshake assertions bound into the HTIF bridge
// valids hold until ready, no core requests taken while busy
`timescale 1ns/1ns

module htif_bridge_asserts (
    input logic clk,
    input logic rst,
    input logic core_awvalid, core_awready, core_wvalid, core_wready,
    input logic core_bvalid, core_bready, core_arvalid, core_arready,
    input logic core_rvalid, core_rready,
    input logic mem_awvalid, mem_awready, mem_wvalid, mem_wready,
    input logic mem_bvalid, mem_bready, mem_arvalid, mem_arready,
    input logic mem_rvalid, mem_rready,
    input logic busy
);
    int fail_cnt = 0;

    property hold_valid(logic v, logic r);
        @(posedge clk) disable iff (rst) v && !r |=> v;
    endproperty

    a_core_aw: assert property (hold_valid(core_awvalid, core_awready)) else begin
        $error("core aw dropped");
        fail_cnt++;
    end
    a_core_w: assert property (hold_valid(core_wvalid, core_wready)) else begin
        $error("core w dropped");
        fail_cnt++;
    end
    a_core_b: assert property (hold_valid(core_bvalid, core_bready)) else begin
        $error("core b dropped");
        fail_cnt++;
    end
    a_core_ar: assert property (hold_valid(core_arvalid, core_arready)) else begin
        $error("core ar dropped");
        fail_cnt++;
    end
    a_core_r: assert property (hold_valid(core_rvalid, core_rready)) else begin
        $error("core r dropped");
        fail_cnt++;
    end
    a_mem_aw: assert property (hold_valid(mem_awvalid, mem_awready)) else begin
        $error("mem aw dropped");
        fail_cnt++;
    end
    a_mem_w: assert property (hold_valid(mem_wvalid, mem_wready)) else begin
        $error("mem w dropped");
        fail_cnt++;
    end
    a_mem_b: assert property (hold_valid(mem_bvalid, mem_bready)) else begin
        $error("mem b dropped");
        fail_cnt++;
    end
    a_mem_ar: assert property (hold_valid(mem_arvalid, mem_arready)) else begin
        $error("mem ar dropped");
        fail_cnt++;
    end
    a_mem_r: assert property (hold_valid(mem_rvalid, mem_rready)) else begin
        $error("mem r dropped");
        fail_cnt++;
    end

    // sequence in flight owns the bus
    a_busy_aw: assert property (@(posedge clk) disable iff (rst)
        !(busy && core_awvalid && core_awready)) else begin
        $error("core aw taken while busy");
        fail_cnt++;
    end
    a_busy_ar: assert property (@(posedge clk) disable iff (rst)
        !(busy && core_arvalid && core_arready)) else begin
        $error("core ar taken while busy");
        fail_cnt++;
    end

endmodule

bind htif_bridge htif_bridge_asserts u_asserts (.*);

// ==== verification/bus_responder.sv ====
// downstream AXI slave model for the HTIF bridge testbench
// sparse memory plus UART-lite data and status registers,
// random ready delays, log of transmitted characters
`timescale 1ns/1ns

module bus_responder import htif_pkg::*; #(
    parameter logic [63:0] UART_BASE = 64'h1000_0000,
    parameter int          SEED      = 53
) (
    input  logic      clk,
    input  logic      rst,
    input  addr_req_t mem_aw,
    input  logic      mem_awvalid,
    output logic      mem_awready,
    input  wdata_t    mem_w,
    input  logic      mem_wvalid,
    output logic      mem_wready,
    output logic      mem_bvalid,
    input  logic      mem_bready,
    input  addr_req_t mem_ar,
    input  logic      mem_arvalid,
    output logic      mem_arready,
    output rdata_t    mem_r,
    output logic      mem_rvalid,
    input  logic      mem_rready
);
    logic [63:0] mem [logic [63:0]];
    logic [63:0] tx_log_data[$];
    logic [7:0]  tx_log_strb[$];
    logic [7:0]  rx_q[$];       // bytes waiting in the rx fifo
    int          tx_full_cnt;   // status polls still reporting tx full
    int          uart_access_cnt;
    integer      seed;

    initial begin
        logic [63:0] addr, cur;
        wdata_t      wd;
        seed = SEED;
        tx_full_cnt = 0;
        uart_access_cnt = 0;
        mem_awready = 1'b0;
        mem_wready  = 1'b0;
        mem_bvalid  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && mem_awvalid && mem_wvalid) begin
                addr = mem_aw.addr;
                wd   = mem_w;
                repeat ($unsigned($random(seed)) % 3) @(posedge clk);
                @(posedge clk);
                #1;
                mem_awready = 1'b1;
                mem_wready  = 1'b1;
                @(posedge clk);
                #1;
                mem_awready = 1'b0;
                mem_wready  = 1'b0;
                if (addr[63:4] == UART_BASE[63:4]) begin
                    uart_access_cnt++;
                    if (addr == UART_BASE) begin  // tx fifo
                        tx_log_data.push_back(wd.data);
                        tx_log_strb.push_back(wd.strb);
                    end
                end else begin
                    cur = mem.exists(addr) ? mem[addr] : addr ^ 64'h5a5a_c3c3_0f0f_9696;
                    for (int b = 0; b < 8; b++) begin
                        if (wd.strb[b]) cur[8*b +: 8] = wd.data[8*b +: 8];
                    end
                    mem[addr] = cur;
                end
                mem_bvalid = 1'b1;
                do @(negedge clk); while (!mem_bready);
                @(posedge clk);
                #1;
                mem_bvalid = 1'b0;
            end
        end
    end

    initial begin
        logic [63:0] addr, rd;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_r       = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_arvalid) begin
                addr = mem_ar.addr;
                repeat ($unsigned($random(seed)) % 3) @(posedge clk);
                @(posedge clk);
                #1;
                mem_arready = 1'b1;
                @(posedge clk);
                #1;
                mem_arready = 1'b0;
                rd = '0;
                if (addr == UART_BASE + 64'h8) begin
                    uart_access_cnt++;
                    if (tx_full_cnt > 0) begin
                        rd[3] = 1'b1;
                        tx_full_cnt--;
                    end
                    if (rx_q.size() > 0) rd[0] = 1'b1;
                end else if (addr == UART_BASE) begin
                    uart_access_cnt++;
                    if (rx_q.size() > 0) rd[7:0] = rx_q.pop_front();
                end else begin
                    rd = mem.exists(addr) ? mem[addr] : addr ^ 64'h5a5a_c3c3_0f0f_9696;
                end
                mem_r      = '{data: rd, last: 1'b1};
                mem_rvalid = 1'b1;
                do @(negedge clk); while (!mem_rready);
                @(posedge clk);
                #1;
                mem_rvalid = 1'b0;
            end
        end
    end

endmodule

// ==== verilog/htif_bridge.sv ====
// HTIF console bridge top level
// steering, tohost/fromhost register slave and UART-lite sequencer
`timescale 1ns/1ns

module htif_bridge import htif_pkg::*; #(
    parameter logic [ADDR_W-1:0] TOHOST_ADDR   = 64'h8000_1000,
    parameter logic [ADDR_W-1:0] FROMHOST_ADDR = 64'h8000_1040,
    parameter logic [ADDR_W-1:0] UART_BASE     = 64'h1000_0000
) (
    input  logic      clk,
    input  logic      rst,
    input  addr_req_t core_aw,
    input  logic      core_awvalid,
    output logic      core_awready,
    input  wdata_t    core_w,
    input  logic      core_wvalid,
    output logic      core_wready,
    output logic      core_bvalid,
    input  logic      core_bready,
    input  addr_req_t core_ar,
    input  logic      core_arvalid,
    output logic      core_arready,
    output rdata_t    core_r,
    output logic      core_rvalid,
    input  logic      core_rready,
    output addr_req_t mem_aw,
    output logic      mem_awvalid,
    input  logic      mem_awready,
    output wdata_t    mem_w,
    output logic      mem_wvalid,
    input  logic      mem_wready,
    input  logic      mem_bvalid,
    output logic      mem_bready,
    output addr_req_t mem_ar,
    output logic      mem_arvalid,
    input  logic      mem_arready,
    input  rdata_t    mem_r,
    input  logic      mem_rvalid,
    output logic      mem_rready
);
    // steer to register slave
    addr_req_t reg_aw, reg_ar;
    wdata_t    reg_w;
    rdata_t    reg_r;
    logic      reg_awvalid, reg_awready, reg_wvalid, reg_wready;
    logic      reg_bvalid, reg_bready;
    logic      reg_arvalid, reg_arready, reg_rvalid, reg_rready;

    // sequencer to steer
    addr_req_t uart_aw, uart_ar;
    wdata_t    uart_w;
    rdata_t    uart_r;
    logic      uart_awvalid, uart_awready, uart_wvalid, uart_wready;
    logic      uart_bvalid, uart_bready;
    logic      uart_arvalid, uart_arready, uart_rvalid, uart_rready;

    logic       htif_sel, busy;
    logic       tx_start, rx_start, seq_done, rx_load;
    logic [7:0] tx_char, rx_byte;

    htif_steer #(
        .TOHOST_ADDR   (TOHOST_ADDR),
        .FROMHOST_ADDR (FROMHOST_ADDR)
    ) u_steer (.*);

    htif_regs #(
        .TOHOST_ADDR   (TOHOST_ADDR),
        .FROMHOST_ADDR (FROMHOST_ADDR)
    ) u_regs (.*);

    uart_lite_seq #(
        .UART_BASE (UART_BASE)
    ) u_seq (.*);

endmodule

// ==== verilog/uart_lite_seq.sv ====
// UART-lite access sequencer
// transmit: poll status until tx fifo has room, write the character
// receive: poll status, read one byte when rx data is present
`timescale 1ns/1ns

module uart_lite_seq import htif_pkg::*; #(
    parameter logic [ADDR_W-1:0] UART_BASE = 64'h1000_0000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic       rx_start,
    input  logic [7:0] tx_char,
    output addr_req_t  uart_aw,
    output logic       uart_awvalid,
    input  logic       uart_awready,
    output wdata_t     uart_w,
    output logic       uart_wvalid,
    input  logic       uart_wready,
    input  logic       uart_bvalid,
    output logic       uart_bready,
    output addr_req_t  uart_ar,
    output logic       uart_arvalid,
    input  logic       uart_arready,
    input  rdata_t     uart_r,
    input  logic       uart_rvalid,
    output logic       uart_rready,
    output logic       seq_done,
    output logic       rx_load,
    output logic [7:0] rx_byte
);
    uart_state_t state;
    logic        rx_mode;

    assign seq_done = state == ST_RECOVER;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            rx_mode      <= 1'b0;
            uart_awvalid <= 1'b0;
            uart_wvalid  <= 1'b0;
            uart_bready  <= 1'b0;
            uart_arvalid <= 1'b0;
            uart_rready  <= 1'b0;
            rx_load      <= 1'b0;
        end else begin
            rx_load <= 1'b0;
            case (state)
                ST_IDLE: if (tx_start || rx_start) begin
                    rx_mode      <= rx_start;
                    uart_ar      <= '{addr: UART_BASE + UART_STAT_OFS, len: '0};
                    uart_arvalid <= 1'b1;
                    state        <= ST_STAT_AR;
                end
                ST_STAT_AR: if (uart_arready) begin
                    uart_arvalid <= 1'b0;
                    uart_rready  <= 1'b1;
                    state        <= ST_STAT_R;
                end
                ST_STAT_R: if (uart_rvalid) begin
                    uart_rready <= 1'b0;
                    if (rx_mode) begin
                        if (uart_r.data[STAT_RX_VALID]) begin
                            uart_ar      <= '{addr: UART_BASE + UART_DATA_OFS, len: '0};
                            uart_arvalid <= 1'b1;
                            state        <= ST_RX_AR;
                        end else begin
                            state <= ST_RECOVER;  // nothing received
                        end
                    end else if (uart_r.data[STAT_TX_FULL]) begin
                        uart_arvalid <= 1'b1;  // poll again
                        state        <= ST_STAT_AR;
                    end else begin
                        uart_aw      <= '{addr: UART_BASE + UART_DATA_OFS, len: '0};
                        uart_w       <= '{data: {24'd0, tx_char, 32'd0},
                                          strb: TX_LANE_STRB, last: 1'b1};
                        uart_awvalid <= 1'b1;
                        uart_wvalid  <= 1'b1;
                        state        <= ST_TX_AW_W;
                    end
                end
                ST_TX_AW_W: begin
                    if (uart_awready) uart_awvalid <= 1'b0;
                    if (uart_wready) uart_wvalid <= 1'b0;
                    if ((!uart_awvalid || uart_awready) && (!uart_wvalid || uart_wready)) begin
                        uart_bready <= 1'b1;
                        state       <= ST_TX_B;
                    end
                end
                ST_TX_B: if (uart_bvalid) begin
                    uart_bready <= 1'b0;
                    state       <= ST_RECOVER;
                end
                ST_RX_AR: if (uart_arready) begin
                    uart_arvalid <= 1'b0;
                    uart_rready  <= 1'b1;
                    state        <= ST_RX_R;
                end
                ST_RX_R: if (uart_rvalid) begin
                    uart_rready <= 1'b0;
                    rx_load     <= 1'b1;
                    rx_byte     <= uart_r.data[7:0];
                    state       <= ST_RECOVER;
                end
                default: state <= ST_IDLE;  // recover
            endcase
        end
    end

endmodule

// ==== verilog/htif_regs.sv ====
// tohost and fromhost registers behind a single-beat AXI slave
// starts the console transmit and receive sequences and
// takes their results back
`timescale 1ns/1ns

module htif_regs import htif_pkg::*; #(
    parameter logic [ADDR_W-1:0] TOHOST_ADDR   = 64'h8000_1000,
    parameter logic [ADDR_W-1:0] FROMHOST_ADDR = 64'h8000_1040
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      htif_sel,
    input  addr_req_t reg_aw,
    input  logic      reg_awvalid,
    output logic      reg_awready,
    input  wdata_t    reg_w,
    input  logic      reg_wvalid,
    output logic      reg_wready,
    output logic      reg_bvalid,
    input  logic      reg_bready,
    input  addr_req_t reg_ar,
    input  logic      reg_arvalid,
    output logic      reg_arready,
    output rdata_t    reg_r,
    output logic      reg_rvalid,
    input  logic      reg_rready,
    output logic      busy,
    output logic      tx_start,
    output logic      rx_start,
    output logic [7:0] tx_char,
    input  logic      seq_done,
    input  logic      rx_load,
    input  logic [7:0] rx_byte
);
    logic [DATA_W-1:0] tohost, fromhost, wdata;
    logic [ADDR_W-1:0] waddr;
    logic              rx_arm;  // fromhost read found zero
    logic              seq_run;
    logic              putc;

    assign putc = tohost[63:56] == HTIF_DEV_CONSOLE && tohost[55:48] == HTIF_CMD_PUTC;

    always_ff @(posedge clk) begin
        if (reg_awvalid && reg_awready) waddr <= reg_aw.addr;
        if (reg_wvalid && reg_wready) wdata <= reg_w.data;
        if (reg_arvalid && reg_arready) begin
            if (reg_ar.addr == TOHOST_ADDR) reg_r.data <= tohost;
            else if (reg_ar.addr == FROMHOST_ADDR) reg_r.data <= fromhost;
            else reg_r.data <= '0;
            reg_r.last <= 1'b1;
        end
        if (reg_bvalid && reg_bready) tx_char <= tohost[7:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_awready <= 1'b1;
            reg_wready  <= 1'b1;
            reg_arready <= 1'b1;
            reg_bvalid  <= 1'b0;
            reg_rvalid  <= 1'b0;
            busy        <= 1'b0;
            tx_start    <= 1'b0;
            rx_start    <= 1'b0;
            rx_arm      <= 1'b0;
            seq_run     <= 1'b0;
            tohost      <= '0;
            fromhost    <= '0;
        end else begin
            tx_start <= 1'b0;
            rx_start <= 1'b0;
            if (htif_sel) busy <= 1'b1;

            if (reg_arvalid && reg_arready) begin
                reg_arready <= 1'b0;
                reg_rvalid  <= 1'b1;
                rx_arm      <= reg_ar.addr == FROMHOST_ADDR && fromhost == '0;
            end
            if (reg_awvalid && reg_awready) reg_awready <= 1'b0;
            if (reg_wvalid && reg_wready) reg_wready <= 1'b0;

            // both AW and W taken
            if (!reg_awready && !reg_wready && !reg_bvalid && !seq_run) begin
                reg_bvalid <= 1'b1;
                if (waddr == TOHOST_ADDR) tohost <= wdata;
                if (waddr == FROMHOST_ADDR) fromhost <= wdata;
            end

            if (reg_rvalid && reg_rready) begin
                reg_rvalid <= 1'b0;
                if (rx_arm) begin
                    rx_start    <= 1'b1;  // poll the uart for input
                    seq_run     <= 1'b1;
                    reg_awready <= 1'b0;
                    reg_wready  <= 1'b0;
                end else begin
                    reg_arready <= 1'b1;
                    busy        <= 1'b0;
                end
            end

            if (reg_bvalid && reg_bready) begin
                reg_bvalid <= 1'b0;
                if (putc) begin
                    tx_start    <= 1'b1;
                    seq_run     <= 1'b1;
                    reg_arready <= 1'b0;
                end else begin
                    reg_awready <= 1'b1;
                    reg_wready  <= 1'b1;
                    tohost      <= '0;
                    busy        <= 1'b0;
                end
            end

            if (rx_load) fromhost <= {HTIF_DEV_CONSOLE, 8'h00, 40'd0, rx_byte};

            if (seq_done) begin
                reg_awready <= 1'b1;
                reg_wready  <= 1'b1;
                reg_arready <= 1'b1;
                seq_run     <= 1'b0;
                busy        <= 1'b0;
                rx_arm      <= 1'b0;
                if (!rx_arm) tohost <= '0;  // character sent
            end
        end
    end

endmodule

// ==== verilog/htif_steer.sv ====
// HTIF address filter and bus steering
// catches single-beat tohost/fromhost requests, holds them off while
// pass-through transactions are outstanding, and muxes core, register
// and UART sequencer channels
`timescale 1ns/1ns

module htif_steer import htif_pkg::*; #(
    parameter logic [ADDR_W-1:0] TOHOST_ADDR   = 64'h8000_1000,
    parameter logic [ADDR_W-1:0] FROMHOST_ADDR = 64'h8000_1040
) (
    input  logic      clk,
    input  logic      rst,
    input  addr_req_t core_aw,
    input  logic      core_awvalid,
    output logic      core_awready,
    input  wdata_t    core_w,
    input  logic      core_wvalid,
    output logic      core_wready,
    output logic      core_bvalid,
    input  logic      core_bready,
    input  addr_req_t core_ar,
    input  logic      core_arvalid,
    output logic      core_arready,
    output rdata_t    core_r,
    output logic      core_rvalid,
    input  logic      core_rready,
    output addr_req_t mem_aw,
    output logic      mem_awvalid,
    input  logic      mem_awready,
    output wdata_t    mem_w,
    output logic      mem_wvalid,
    input  logic      mem_wready,
    input  logic      mem_bvalid,
    output logic      mem_bready,
    output addr_req_t mem_ar,
    output logic      mem_arvalid,
    input  logic      mem_arready,
    input  rdata_t    mem_r,
    input  logic      mem_rvalid,
    output logic      mem_rready,
    output addr_req_t reg_aw,
    output logic      reg_awvalid,
    input  logic      reg_awready,
    output wdata_t    reg_w,
    output logic      reg_wvalid,
    input  logic      reg_wready,
    input  logic      reg_bvalid,
    output logic      reg_bready,
    output addr_req_t reg_ar,
    output logic      reg_arvalid,
    input  logic      reg_arready,
    input  rdata_t    reg_r,
    input  logic      reg_rvalid,
    output logic      reg_rready,
    input  addr_req_t uart_aw,
    input  logic      uart_awvalid,
    output logic      uart_awready,
    input  wdata_t    uart_w,
    input  logic      uart_wvalid,
    output logic      uart_wready,
    output logic      uart_bvalid,
    input  logic      uart_bready,
    input  addr_req_t uart_ar,
    input  logic      uart_arvalid,
    output logic      uart_arready,
    output rdata_t    uart_r,
    output logic      uart_rvalid,
    input  logic      uart_rready,
    input  logic      busy,
    output logic      htif_sel
);
    logic       hit_aw, hit_ar;
    logic       aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic [3:0] txn_cnt;  // pass-through requests awaiting a response
    logic [3:0] wdat_cnt; // pass-through AWs still owed write data

    always_comb begin
        hit_aw = core_awvalid && core_aw.len == '0 &&
                 (core_aw.addr == TOHOST_ADDR || core_aw.addr == FROMHOST_ADDR);
        hit_ar = core_arvalid && core_ar.len == '0 &&
                 (core_ar.addr == TOHOST_ADDR || core_ar.addr == FROMHOST_ADDR);
    end

    assign htif_sel = ((hit_aw || hit_ar) && txn_cnt == '0) || busy;

    // pass-through handshakes
    assign aw_hs = mem_awvalid && mem_awready && !htif_sel;
    assign w_hs  = mem_wvalid && mem_wready && mem_w.last && !htif_sel;
    assign b_hs  = mem_bvalid && mem_bready && !htif_sel;
    assign ar_hs = mem_arvalid && mem_arready && !htif_sel;
    assign r_hs  = mem_rvalid && mem_rready && mem_r.last && !htif_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            txn_cnt  <= '0;
            wdat_cnt <= '0;
        end else begin
            txn_cnt  <= txn_cnt + 4'(aw_hs) + 4'(ar_hs) - 4'(b_hs) - 4'(r_hs);
            wdat_cnt <= wdat_cnt + 4'(aw_hs) - 4'(w_hs);
        end
    end

    // request channels
    assign reg_aw       = core_aw;
    assign reg_awvalid  = htif_sel && core_awvalid;
    assign mem_aw       = htif_sel ? uart_aw : core_aw;
    assign mem_awvalid  = htif_sel ? uart_awvalid : core_awvalid && !hit_aw;
    assign core_awready = htif_sel ? reg_awready : mem_awready && !hit_aw;
    assign uart_awready = htif_sel && mem_awready;

    assign reg_w        = core_w;
    assign reg_wvalid   = htif_sel && core_wvalid;
    assign mem_w        = htif_sel ? uart_w : core_w;
    assign mem_wvalid   = htif_sel ? uart_wvalid :
                          core_wvalid && (wdat_cnt != '0 || !hit_aw); // htif data waits
    assign core_wready  = htif_sel ? reg_wready :
                          mem_wready && (wdat_cnt != '0 || !hit_aw);
    assign uart_wready  = htif_sel && mem_wready;

    assign reg_ar       = core_ar;
    assign reg_arvalid  = htif_sel && core_arvalid;
    assign mem_ar       = htif_sel ? uart_ar : core_ar;
    assign mem_arvalid  = htif_sel ? uart_arvalid : core_arvalid && !hit_ar;
    assign core_arready = htif_sel ? reg_arready : mem_arready && !hit_ar;
    assign uart_arready = htif_sel && mem_arready;

    // response channels
    assign core_bvalid  = htif_sel ? reg_bvalid : mem_bvalid;
    assign reg_bready   = htif_sel && core_bready;
    assign mem_bready   = htif_sel ? uart_bready : core_bready;
    assign uart_bvalid  = htif_sel && mem_bvalid;

    assign core_r       = htif_sel ? reg_r : mem_r;
    assign core_rvalid  = htif_sel ? reg_rvalid : mem_rvalid;
    assign reg_rready   = htif_sel && core_rready;
    assign mem_rready   = htif_sel ? uart_rready : core_rready;
    assign uart_r       = mem_r;
    assign uart_rvalid  = htif_sel && mem_rvalid;

endmodule

// ==== verilog/htif_pkg.sv ====
// shared definitions for the HTIF console bridge
// bus widths, AXI channel payloads, HTIF codes,
// UART-lite register map and sequencer states
package htif_pkg;

    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;

    // AW or AR payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } addr_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } wdata_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } rdata_t;

    localparam logic [7:0] HTIF_DEV_CONSOLE = 8'd1;  // tohost[63:56]
    localparam logic [7:0] HTIF_CMD_PUTC    = 8'd1;  // tohost[55:48]

    localparam logic [ADDR_W-1:0] UART_DATA_OFS = 64'h0;  // tx/rx fifo
    localparam logic [ADDR_W-1:0] UART_STAT_OFS = 64'h8;

    localparam int STAT_RX_VALID = 0;
    localparam int STAT_TX_FULL  = 3;

    localparam logic [STRB_W-1:0] TX_LANE_STRB = 8'h10;  // byte lane 4

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_STAT_AR,
        ST_STAT_R,
        ST_TX_AW_W,
        ST_TX_B,
        ST_RX_AR,
        ST_RX_R,
        ST_RECOVER
    } uart_state_t;

endpackage
